// ==== rtl/cpu_bus_pkg.sv ====
// Bus widths, SRAM geometry and Wishbone cycle-type codes shared by the memory subsystem.
package cpu_bus_pkg;

	// Byte address and data path widths.
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// One select bit per byte lane.
	localparam int SEL_W = DATA_W / 8;

	// On-chip SRAM depth in words and the width of its word index.
	localparam int MEM_WORDS = 1024;
	localparam int MEM_AW = 10;

	// Instruction fetch bursts carry 1 to 4 words.
	localparam int BURST_MAX = 4;
	localparam int LEN_W = 3;

	// Width of the Wishbone CTI field.
	localparam int CTI_W = 3;

	// Classic cycle, a single word.
	localparam logic [CTI_W-1:0] CTI_CLASSIC = 3'b000;

	// Incrementing burst, more beats follow.
	localparam logic [CTI_W-1:0] CTI_INCR = 3'b010;

	// Last beat of a burst.
	localparam logic [CTI_W-1:0] CTI_END = 3'b111;

endpackage

// ==== rtl/wb_fetch_port.sv ====
// Instruction fetch master that turns core fetch requests into read-only Wishbone bursts.
`timescale 1ns/1ps

module wb_fetch_port (
	input  logic                              clk_i,
	input  logic                              rst_n_i,

	input  logic                              fetch_req_i,
	input  logic [cpu_bus_pkg::ADDR_W-1:0]    fetch_addr_i,
	input  logic [cpu_bus_pkg::LEN_W-1:0]     fetch_len_i,
	output logic [cpu_bus_pkg::DATA_W-1:0]    fetch_data_o,
	output logic                              fetch_valid_o,
	output logic                              fetch_done_o,
	output logic                              fetch_busy_o,
	output logic                              fetch_stall_o,

	output logic [cpu_bus_pkg::ADDR_W-1:0]    wb_adr_o,
	output logic [cpu_bus_pkg::CTI_W-1:0]     wb_cti_o,
	output logic                              wb_cyc_o,
	output logic                              wb_stb_o,
	input  logic [cpu_bus_pkg::DATA_W-1:0]    wb_dat_i,
	input  logic                              wb_ack_i
);

	logic                           cyc_q;
	logic                           stb_q;
	logic                           burst_q;
	logic [cpu_bus_pkg::ADDR_W-1:0] adr_q;
	logic [cpu_bus_pkg::LEN_W-1:0]  left_q;
	logic [cpu_bus_pkg::LEN_W-1:0]  len_clamped;
	logic                           accept;
	logic                           beat;
	logic                           last_beat;

	// A new request is taken only while no cycle is open.
	assign accept = fetch_req_i & ~cyc_q;
	assign beat = cyc_q & stb_q & wb_ack_i;
	assign last_beat = (left_q == cpu_bus_pkg::LEN_W'(1));

	// Keep the length inside 1 to BURST_MAX words.
	always_comb begin
		if (fetch_len_i == '0) begin
			len_clamped = cpu_bus_pkg::LEN_W'(1);
		end else if (fetch_len_i > cpu_bus_pkg::LEN_W'(cpu_bus_pkg::BURST_MAX)) begin
			len_clamped = cpu_bus_pkg::LEN_W'(cpu_bus_pkg::BURST_MAX);
		end else begin
			len_clamped = fetch_len_i;
		end
	end

	// Cycle control and remaining beat count.
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cyc_q <= 1'b0;
			stb_q <= 1'b0;
			left_q <= '0;
		end else if (accept) begin
			cyc_q <= 1'b1;
			stb_q <= 1'b1;
			left_q <= len_clamped;
		end else if (beat) begin
			if (last_beat) begin
				cyc_q <= 1'b0;
				stb_q <= 1'b0;
			end
			left_q <= left_q - 1'b1;
		end
	end

	// Address advances one word per acknowledged beat.
	always_ff @(posedge clk_i) begin
		if (accept) begin
			adr_q <= {fetch_addr_i[cpu_bus_pkg::ADDR_W-1:2], 2'b00};
			burst_q <= (len_clamped != cpu_bus_pkg::LEN_W'(1));
		end else if (beat && !last_beat) begin
			adr_q <= adr_q + cpu_bus_pkg::ADDR_W'(4);
		end
	end

	// Single words go out as classic cycles, bursts close with an end beat.
	always_comb begin
		if (!last_beat) begin
			wb_cti_o = cpu_bus_pkg::CTI_INCR;
		end else if (burst_q) begin
			wb_cti_o = cpu_bus_pkg::CTI_END;
		end else begin
			wb_cti_o = cpu_bus_pkg::CTI_CLASSIC;
		end
	end

	assign wb_adr_o = adr_q;
	assign wb_cyc_o = cyc_q;
	assign wb_stb_o = stb_q;

	// Each acknowledged word goes straight back to the core.
	assign fetch_data_o = wb_dat_i;
	assign fetch_valid_o = beat;
	assign fetch_done_o = beat & last_beat;
	assign fetch_busy_o = cyc_q;
	assign fetch_stall_o = cyc_q & stb_q & ~wb_ack_i;

	// An open cycle always has at least one beat left to run.
	a_beats_left: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_cyc_o |-> (left_q != '0))
		else $error("fetch cycle open with no beats left");

endmodule

// ==== rtl/wb_data_port.sv ====
// Load/store master that runs each core access as one classic Wishbone cycle.
`timescale 1ns/1ps

module wb_data_port (
	input  logic                              clk_i,
	input  logic                              rst_n_i,

	input  logic                              data_req_i,
	input  logic                              data_we_i,
	input  logic [cpu_bus_pkg::ADDR_W-1:0]    data_addr_i,
	input  logic [cpu_bus_pkg::DATA_W-1:0]    data_wdata_i,
	input  logic [cpu_bus_pkg::SEL_W-1:0]     data_sel_i,
	output logic [cpu_bus_pkg::DATA_W-1:0]    data_rdata_o,
	output logic                              data_done_o,
	output logic                              data_busy_o,
	output logic                              data_stall_o,

	output logic [cpu_bus_pkg::ADDR_W-1:0]    wb_adr_o,
	output logic [cpu_bus_pkg::DATA_W-1:0]    wb_dat_o,
	output logic [cpu_bus_pkg::SEL_W-1:0]     wb_sel_o,
	output logic                              wb_we_o,
	output logic [cpu_bus_pkg::CTI_W-1:0]     wb_cti_o,
	output logic                              wb_cyc_o,
	output logic                              wb_stb_o,
	input  logic [cpu_bus_pkg::DATA_W-1:0]    wb_dat_i,
	input  logic                              wb_ack_i
);

	logic                           cyc_q;
	logic                           stb_q;
	logic                           done_q;
	logic                           we_q;
	logic [cpu_bus_pkg::ADDR_W-1:0] adr_q;
	logic [cpu_bus_pkg::DATA_W-1:0] dat_q;
	logic [cpu_bus_pkg::SEL_W-1:0]  sel_q;
	logic [cpu_bus_pkg::DATA_W-1:0] rdata_q;
	logic                           accept;
	logic                           ack;

	assign accept = data_req_i & ~cyc_q;
	assign ack = cyc_q & stb_q & wb_ack_i;

	// Cycle control, closed by the single acknowledge.
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cyc_q <= 1'b0;
			stb_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= ack;
			if (accept) begin
				cyc_q <= 1'b1;
				stb_q <= 1'b1;
			end else if (ack) begin
				cyc_q <= 1'b0;
				stb_q <= 1'b0;
			end
		end
	end

	// Access fields are held for the whole cycle.
	always_ff @(posedge clk_i) begin
		if (accept) begin
			adr_q <= data_addr_i;
			dat_q <= data_wdata_i;
			sel_q <= data_sel_i;
			we_q <= data_we_i;
		end
		if (ack) begin
			rdata_q <= wb_dat_i;
		end
	end

	assign wb_adr_o = adr_q;
	assign wb_dat_o = dat_q;
	assign wb_sel_o = sel_q;
	assign wb_we_o = we_q;
	assign wb_cti_o = cpu_bus_pkg::CTI_CLASSIC;
	assign wb_cyc_o = cyc_q;
	assign wb_stb_o = stb_q;

	// Read data lines up with done, one cycle after the acknowledge.
	assign data_rdata_o = rdata_q;
	assign data_done_o = done_q;
	assign data_busy_o = cyc_q;
	assign data_stall_o = cyc_q & stb_q & ~wb_ack_i;

	a_hold_until_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(wb_stb_o && !wb_ack_i) |=> ($stable(wb_adr_o) && $stable(wb_we_o)))
		else $error("data port changed ADR or WE before ACK");

endmodule

// ==== rtl/wb_arbiter.sv ====
// Round-robin arbiter that shares one Wishbone slave between the fetch and data masters.
`timescale 1ns/1ps

module wb_arbiter (
	input  logic                              clk_i,
	input  logic                              rst_n_i,

	// Instruction fetch master.
	input  logic [cpu_bus_pkg::ADDR_W-1:0]    i_adr_i,
	input  logic [cpu_bus_pkg::CTI_W-1:0]     i_cti_i,
	input  logic                              i_cyc_i,
	input  logic                              i_stb_i,
	output logic                              i_ack_o,

	// Load/store master.
	input  logic [cpu_bus_pkg::ADDR_W-1:0]    d_adr_i,
	input  logic [cpu_bus_pkg::DATA_W-1:0]    d_dat_i,
	input  logic [cpu_bus_pkg::SEL_W-1:0]     d_sel_i,
	input  logic                              d_we_i,
	input  logic [cpu_bus_pkg::CTI_W-1:0]     d_cti_i,
	input  logic                              d_cyc_i,
	input  logic                              d_stb_i,
	output logic                              d_ack_o,

	output logic [cpu_bus_pkg::DATA_W-1:0]    m_dat_o,

	// Slave side.
	output logic [cpu_bus_pkg::ADDR_W-1:0]    s_adr_o,
	output logic [cpu_bus_pkg::DATA_W-1:0]    s_dat_o,
	output logic [cpu_bus_pkg::SEL_W-1:0]     s_sel_o,
	output logic                              s_we_o,
	output logic [cpu_bus_pkg::CTI_W-1:0]     s_cti_o,
	output logic                              s_cyc_o,
	output logic                              s_stb_o,
	input  logic [cpu_bus_pkg::DATA_W-1:0]    s_dat_i,
	input  logic                              s_ack_i
);

	// Grant encoding is 0 for fetch and 1 for data.
	logic gnt;
	logic last_q;
	logic locked_q;
	logic owner_cyc;

	assign owner_cyc = last_q ? d_cyc_i : i_cyc_i;

	// The owner keeps the bus until it drops CYC.
	always_comb begin
		if (locked_q && owner_cyc) begin
			gnt = last_q;
		end else if (i_cyc_i && d_cyc_i) begin
			gnt = ~last_q;
		end else if (d_cyc_i) begin
			gnt = 1'b1;
		end else if (i_cyc_i) begin
			gnt = 1'b0;
		end else begin
			gnt = last_q;
		end
	end

	// Reset leaves data as last granted so fetch wins the first tie.
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			last_q <= 1'b1;
			locked_q <= 1'b0;
		end else begin
			last_q <= gnt;
			locked_q <= gnt ? d_cyc_i : i_cyc_i;
		end
	end

	// Fetch cycles are always full-word reads.
	assign s_adr_o = gnt ? d_adr_i : i_adr_i;
	assign s_dat_o = d_dat_i;
	assign s_sel_o = gnt ? d_sel_i : '1;
	assign s_we_o = gnt & d_we_i;
	assign s_cti_o = gnt ? d_cti_i : i_cti_i;
	assign s_cyc_o = gnt ? d_cyc_i : i_cyc_i;
	assign s_stb_o = gnt ? d_stb_i : i_stb_i;

	assign i_ack_o = ~gnt & i_cyc_i & s_ack_i;
	assign d_ack_o = gnt & d_cyc_i & s_ack_i;
	assign m_dat_o = s_dat_i;

	// A cycle still waiting for ACK keeps the slave bus.
	a_hold_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(s_cyc_o && s_stb_o && !s_ack_i) |=>
			(s_cyc_o && $stable(s_adr_o) && $stable(s_we_o)))
		else $error("grant moved away from a cycle still waiting for ACK");

endmodule

// ==== rtl/wb_sram.sv ====
// Wishbone slave SRAM with byte-lane writes and one acknowledge per cycle during bursts.
`timescale 1ns/1ps

module wb_sram (
	input  logic                              clk_i,
	input  logic                              rst_n_i,

	input  logic [cpu_bus_pkg::ADDR_W-1:0]    wb_adr_i,
	input  logic [cpu_bus_pkg::DATA_W-1:0]    wb_dat_i,
	input  logic [cpu_bus_pkg::SEL_W-1:0]     wb_sel_i,
	input  logic                              wb_we_i,
	input  logic [cpu_bus_pkg::CTI_W-1:0]     wb_cti_i,
	input  logic                              wb_cyc_i,
	input  logic                              wb_stb_i,
	output logic [cpu_bus_pkg::DATA_W-1:0]    wb_dat_o,
	output logic                              wb_ack_o
);

	logic [cpu_bus_pkg::DATA_W-1:0] mem [cpu_bus_pkg::MEM_WORDS];
	logic [cpu_bus_pkg::DATA_W-1:0] dat_q;
	logic                           ack_q;
	logic [cpu_bus_pkg::MEM_AW-1:0] idx;
	logic [cpu_bus_pkg::MEM_AW-1:0] rd_idx;
	logic                           req;
	logic                           burst_go;

	initial begin
		for (int k = 0; k < cpu_bus_pkg::MEM_WORDS; k++) begin
			mem[k] = '0;
		end
	end

	// Upper address bits are ignored, the image repeats every 4 KiB.
	assign idx = wb_adr_i[cpu_bus_pkg::MEM_AW+1:2];
	assign req = wb_cyc_i & wb_stb_i;

	// While a burst beat is being acknowledged, fetch the word after it.
	assign burst_go = req & ack_q & (wb_cti_i == cpu_bus_pkg::CTI_INCR);
	assign rd_idx = burst_go ? idx + 1'b1 : idx;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req & (~ack_q | burst_go);
		end
	end

	// Writes land once, in the wait cycle before ACK.
	always_ff @(posedge clk_i) begin
		if (req && !ack_q && wb_we_i) begin
			for (int b = 0; b < cpu_bus_pkg::SEL_W; b++) begin
				if (wb_sel_i[b]) begin
					mem[idx][8*b +: 8] <= wb_dat_i[8*b +: 8];
				end
			end
		end
		if (req) begin
			dat_q <= mem[rd_idx];
		end
	end

	assign wb_dat_o = dat_q;
	assign wb_ack_o = ack_q;

	a_ack_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_ack_o |-> wb_cyc_i)
		else $error("SRAM ACK outside a bus cycle");

endmodule

// ==== rtl/cpu_mem_subsys.sv ====
// Memory side of the processor tile, two Wishbone masters sharing one SRAM.
`timescale 1ns/1ps

module cpu_mem_subsys (
	input  logic                              clk_i,
	input  logic                              rst_n_i,

	input  logic                              fetch_req_i,
	input  logic [cpu_bus_pkg::ADDR_W-1:0]    fetch_addr_i,
	input  logic [cpu_bus_pkg::LEN_W-1:0]     fetch_len_i,
	output logic [cpu_bus_pkg::DATA_W-1:0]    fetch_data_o,
	output logic                              fetch_valid_o,
	output logic                              fetch_done_o,
	output logic                              fetch_busy_o,
	output logic                              fetch_stall_o,

	input  logic                              data_req_i,
	input  logic                              data_we_i,
	input  logic [cpu_bus_pkg::ADDR_W-1:0]    data_addr_i,
	input  logic [cpu_bus_pkg::DATA_W-1:0]    data_wdata_i,
	input  logic [cpu_bus_pkg::SEL_W-1:0]     data_sel_i,
	output logic [cpu_bus_pkg::DATA_W-1:0]    data_rdata_o,
	output logic                              data_done_o,
	output logic                              data_busy_o,
	output logic                              data_stall_o
);

	// Fetch master bus.
	logic [cpu_bus_pkg::ADDR_W-1:0] i_adr;
	logic [cpu_bus_pkg::CTI_W-1:0]  i_cti;
	logic                           i_cyc;
	logic                           i_stb;
	logic                           i_ack;

	// Data master bus.
	logic [cpu_bus_pkg::ADDR_W-1:0] d_adr;
	logic [cpu_bus_pkg::DATA_W-1:0] d_dat;
	logic [cpu_bus_pkg::SEL_W-1:0]  d_sel;
	logic                           d_we;
	logic [cpu_bus_pkg::CTI_W-1:0]  d_cti;
	logic                           d_cyc;
	logic                           d_stb;
	logic                           d_ack;

	// Read data shared by both masters.
	logic [cpu_bus_pkg::DATA_W-1:0] m_dat;

	// Slave bus into the SRAM.
	logic [cpu_bus_pkg::ADDR_W-1:0] s_adr;
	logic [cpu_bus_pkg::DATA_W-1:0] s_dat_w;
	logic [cpu_bus_pkg::DATA_W-1:0] s_dat_r;
	logic [cpu_bus_pkg::SEL_W-1:0]  s_sel;
	logic                           s_we;
	logic [cpu_bus_pkg::CTI_W-1:0]  s_cti;
	logic                           s_cyc;
	logic                           s_stb;
	logic                           s_ack;

	wb_fetch_port u_fetch (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.fetch_req_i(fetch_req_i), .fetch_addr_i(fetch_addr_i), .fetch_len_i(fetch_len_i),
		.fetch_data_o(fetch_data_o), .fetch_valid_o(fetch_valid_o),
		.fetch_done_o(fetch_done_o), .fetch_busy_o(fetch_busy_o),
		.fetch_stall_o(fetch_stall_o),
		.wb_adr_o(i_adr), .wb_cti_o(i_cti), .wb_cyc_o(i_cyc), .wb_stb_o(i_stb),
		.wb_dat_i(m_dat), .wb_ack_i(i_ack)
	);

	wb_data_port u_data (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.data_req_i(data_req_i), .data_we_i(data_we_i), .data_addr_i(data_addr_i),
		.data_wdata_i(data_wdata_i), .data_sel_i(data_sel_i),
		.data_rdata_o(data_rdata_o), .data_done_o(data_done_o),
		.data_busy_o(data_busy_o), .data_stall_o(data_stall_o),
		.wb_adr_o(d_adr), .wb_dat_o(d_dat), .wb_sel_o(d_sel), .wb_we_o(d_we),
		.wb_cti_o(d_cti), .wb_cyc_o(d_cyc), .wb_stb_o(d_stb),
		.wb_dat_i(m_dat), .wb_ack_i(d_ack)
	);

	wb_arbiter u_arb (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.i_adr_i(i_adr), .i_cti_i(i_cti), .i_cyc_i(i_cyc), .i_stb_i(i_stb), .i_ack_o(i_ack),
		.d_adr_i(d_adr), .d_dat_i(d_dat), .d_sel_i(d_sel), .d_we_i(d_we),
		.d_cti_i(d_cti), .d_cyc_i(d_cyc), .d_stb_i(d_stb), .d_ack_o(d_ack),
		.m_dat_o(m_dat),
		.s_adr_o(s_adr), .s_dat_o(s_dat_w), .s_sel_o(s_sel), .s_we_o(s_we),
		.s_cti_o(s_cti), .s_cyc_o(s_cyc), .s_stb_o(s_stb),
		.s_dat_i(s_dat_r), .s_ack_i(s_ack)
	);

	wb_sram u_sram (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.wb_adr_i(s_adr), .wb_dat_i(s_dat_w), .wb_sel_i(s_sel), .wb_we_i(s_we),
		.wb_cti_i(s_cti), .wb_cyc_i(s_cyc), .wb_stb_i(s_stb),
		.wb_dat_o(s_dat_r), .wb_ack_o(s_ack)
	);

endmodule

// ==== tests/tb_cpu_mem_subsys.sv ====
// Self-checking testbench for the memory subsystem, driven by a file of access vectors.
`timescale 1ns/1ps

module tb_cpu_mem_subsys;

	logic                           clk;
	logic                           rst_n;
	logic                           fetch_req;
	logic [cpu_bus_pkg::ADDR_W-1:0] fetch_addr;
	logic [cpu_bus_pkg::LEN_W-1:0]  fetch_len;
	logic [cpu_bus_pkg::DATA_W-1:0] fetch_data;
	logic                           fetch_valid;
	logic                           fetch_done;
	logic                           fetch_busy;
	logic                           fetch_stall;
	logic                           data_req;
	logic                           data_we;
	logic [cpu_bus_pkg::ADDR_W-1:0] data_addr;
	logic [cpu_bus_pkg::DATA_W-1:0] data_wdata;
	logic [cpu_bus_pkg::SEL_W-1:0]  data_sel;
	logic [cpu_bus_pkg::DATA_W-1:0] data_rdata;
	logic                           data_done;
	logic                           data_busy;
	logic                           data_stall;

	// Shadow of the SRAM contents, kept from the writes the testbench issues.
	logic [cpu_bus_pkg::DATA_W-1:0] shadow [cpu_bus_pkg::MEM_WORDS];

	// Fields of the current vector line.
	logic [cpu_bus_pkg::ADDR_W-1:0] f_addr;
	int                             f_len;
	logic [cpu_bus_pkg::DATA_W-1:0] f_exp [cpu_bus_pkg::BURST_MAX];
	logic                           d_we;
	logic [cpu_bus_pkg::ADDR_W-1:0] d_addr;
	logic [cpu_bus_pkg::DATA_W-1:0] d_wdata;
	logic [cpu_bus_pkg::SEL_W-1:0]  d_sel;
	logic [cpu_bus_pkg::DATA_W-1:0] d_exp;

	int errors = 0;
	int tests = 0;
	int failed = 0;
	int seed = 57;

	cpu_mem_subsys i_cpu_mem_subsys (
		.clk_i(clk), .rst_n_i(rst_n),
		.fetch_req_i(fetch_req), .fetch_addr_i(fetch_addr), .fetch_len_i(fetch_len),
		.fetch_data_o(fetch_data), .fetch_valid_o(fetch_valid), .fetch_done_o(fetch_done),
		.fetch_busy_o(fetch_busy), .fetch_stall_o(fetch_stall),
		.data_req_i(data_req), .data_we_i(data_we), .data_addr_i(data_addr),
		.data_wdata_i(data_wdata), .data_sel_i(data_sel), .data_rdata_o(data_rdata),
		.data_done_o(data_done), .data_busy_o(data_busy), .data_stall_o(data_stall)
	);

	always #2 clk = ~clk;

	// Word index inside the SRAM, upper address bits alias.
	function automatic int word_idx(input logic [cpu_bus_pkg::ADDR_W-1:0] a);
		return int'(a[cpu_bus_pkg::MEM_AW+1:2]);
	endfunction

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("CHECK FAILED time %0t ns: %s expected %h, got %h",
				$time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic shadow_write(input logic [31:0] a, input logic [31:0] d,
		input logic [3:0] s);
		for (int b = 0; b < cpu_bus_pkg::SEL_W; b++) begin
			if (s[b]) begin
				shadow[word_idx(a)][8*b +: 8] = d[8*b +: 8];
			end
		end
	endtask

	task automatic read_fetch_fields(input int fd);
		int r;
		r = $fscanf(fd, "%h %h", f_addr, f_len);
		for (int i = 0; i < f_len && i < cpu_bus_pkg::BURST_MAX; i++) begin
			r = $fscanf(fd, "%h", f_exp[i]);
		end
	endtask

	task automatic read_data_fields(input int fd, input logic [7:0] op);
		int r;
		d_we = (op == "W");
		d_sel = '1;
		d_wdata = '0;
		d_exp = '0;
		if (op == "W") begin
			r = $fscanf(fd, "%h %h %h", d_addr, d_wdata, d_sel);
		end else if (op == "R") begin
			r = $fscanf(fd, "%h %h", d_addr, d_exp);
		end else begin
			$display("Vector file holds an unknown opcode %c", op);
			errors++;
		end
	endtask

	// Starts the selected requests in one cycle and follows them until done.
	task automatic run_access(input bit use_f, input bit use_d, input bit timed);
		int k;
		int beats;
		bit f_end;
		bit d_end;
		bit f_stalled;
		bit d_stalled;
		k = 0;
		beats = 0;
		f_end = !use_f;
		d_end = !use_d;
		f_stalled = 1'b0;
		d_stalled = 1'b0;
		fetch_req = use_f;
		fetch_addr = f_addr;
		fetch_len = f_len[cpu_bus_pkg::LEN_W-1:0];
		data_req = use_d;
		data_we = d_we;
		data_addr = d_addr;
		data_wdata = d_wdata;
		data_sel = d_sel;
		// This edge accepts the requests.
		@(posedge clk);
		#1;
		fetch_req = 1'b0;
		data_req = 1'b0;
		// Sample k falls in the cycle k + 1 after acceptance.
		while (!(f_end && d_end) && k < 100) begin
			@(negedge clk);
			f_stalled |= fetch_stall;
			d_stalled |= data_stall;
			if (!f_end && fetch_valid) begin
				if (beats < f_len) begin
					check_value("fetch_data_o", f_exp[beats], fetch_data);
					check_value("fetch_data_o (shadow)",
						shadow[word_idx(f_addr + 4 * beats)], fetch_data);
				end
				beats++;
				if (timed) check_value("fetch_valid_o cycle", beats + 1, k + 1);
				check_value("fetch_done_o", beats == f_len, fetch_done);
				f_end = fetch_done;
			end
			if (!d_end && data_done) begin
				if (timed) check_value("data_done_o cycle", 3, k + 1);
				if (!d_we) begin
					check_value("data_rdata_o", d_exp, data_rdata);
					check_value("data_rdata_o (shadow)", shadow[word_idx(d_addr)], data_rdata);
				end else begin
					shadow_write(d_addr, d_wdata, d_sel);
				end
				d_end = 1'b1;
			end
			k++;
		end
		if (!(f_end && d_end)) begin
			$display("Timeout at %0t ns: access did not finish within 100 cycles", $time);
			errors++;
		end
		if (use_f) check_value("fetch_valid_o count", f_len, beats);
		if (use_f && use_d) begin
			check_value("fetch_stall_o seen high", 1, f_stalled);
			check_value("data_stall_o seen high", 1, d_stalled);
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests++;
		if (errors != errs_before) failed++;
		$display("test %0d %s: %s", tests, name, (errors == errs_before) ? "ok" : "failed");
	endtask

	initial begin : main_seq
		int fd;
		int r;
		int gap;
		int errs_before;
		logic [63:0] tok;
		logic [7:0] op;
		logic [8*200-1:0] line;
		bit use_f;
		bit use_d;
		clk = 1'b0;
		rst_n = 1'b0;
		fetch_req = 1'b0;
		fetch_addr = '0;
		fetch_len = '0;
		data_req = 1'b0;
		data_we = 1'b0;
		data_addr = '0;
		data_wdata = '0;
		data_sel = '0;
		for (int i = 0; i < cpu_bus_pkg::MEM_WORDS; i++) begin
			shadow[i] = '0;
		end
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Both masters stay idle until the first request.
		errs_before = errors;
		repeat (2) begin
			@(negedge clk);
			check_value("fetch_valid_o", 0, fetch_valid);
			check_value("fetch_done_o", 0, fetch_done);
			check_value("fetch_busy_o", 0, fetch_busy);
			check_value("data_done_o", 0, data_done);
			check_value("data_busy_o", 0, data_busy);
		end
		finish_test("reset state", errs_before);

		fd = $fopen("tests/mem_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file tests/mem_vectors.txt");
			errors++;
		end else begin
			r = $fscanf(fd, "%s", tok);
			while (r == 1) begin
				op = tok[7:0];
				if (op == "#") begin
					r = $fgets(line, fd);
				end else begin
					errs_before = errors;
					use_f = (op == "F") || (op == "C");
					use_d = (op != "F");
					if (use_f) read_fetch_fields(fd);
					if (op == "C") r = $fscanf(fd, "%s", tok);
					if (use_d) read_data_fields(fd, (op == "C") ? tok[7:0] : op);
					// A short random idle gap between operations.
					gap = $unsigned($random(seed)) % 3;
					repeat (gap + 1) tick();
					run_access(use_f, use_d, !(use_f && use_d));
					finish_test($sformatf("op %c", op), errs_before);
				end
				r = $fscanf(fd, "%s", tok);
			end
			$fclose(fd);
		end

		$display("%0d tests, %0d failed, %0d check errors", tests, failed, errors);
		if (errors == 0 && failed == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== cpu_mem_subsys.f ====
rtl/cpu_bus_pkg.sv
rtl/wb_fetch_port.sv
rtl/wb_data_port.sv
rtl/wb_arbiter.sv
rtl/wb_sram.sv
rtl/cpu_mem_subsys.sv
tests/tb_cpu_mem_subsys.sv

// ==== tests/mem_vectors.txt ====
# W addr data sel | R addr expect | F addr len expect... (all fields hex)
# C faddr flen fexpect... then W or R with its fields, both started in one cycle
W 00000000 11111111 f
W 00000004 22222222 f
W 00000008 33333333 f
W 0000000c 44444444 f
R 00000000 11111111
R 0000000c 44444444
W 00000010 aabbccdd f
W 00000010 00000055 1
W 00000010 12340000 c
W 00000010 00ee0000 4
R 00000010 12eecc55
F 00000000 1 11111111
F 00000004 2 22222222 33333333
F 00000000 3 11111111 22222222 33333333
F 00000000 4 11111111 22222222 33333333 44444444
W 00001020 cafef00d f
R 00000020 cafef00d
W 00000024 0badbeef f
R 00002024 0badbeef
C 00000000 4 11111111 22222222 33333333 44444444 R 00000010 12eecc55
F 00000008 1 33333333
C 00000004 2 22222222 33333333 W 00000030 5a5a5a5a f
R 00000030 5a5a5a5a
C 00001008 1 33333333 R 00001024 0badbeef
